// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_laser310
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bus_cycle/bus_cycle_seq.sv
module bus_cycle_seq (
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic valid_i,
	input  logic turbo_i,
	output logic ready_o,
	output logic wr_phase_o,
	output logic rd_capture_o
);

	localparam logic [3:0] STRETCH_LAST = 4'd9;	// Ten wait cycles at normal speed

	laser310_pkg::bus_phase_e state;
	logic                     turbo_q;
	logic [3:0]               stretch_cnt;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state       <= laser310_pkg::IDLE;
			turbo_q     <= 1'b0;
			stretch_cnt <= 4'd0;
		end
		else
		begin
			case (state)
				laser310_pkg::IDLE:
				begin
					if (valid_i)
					begin
						state   <= laser310_pkg::SETUP;
						turbo_q <= turbo_i;	// Speed fixed for the whole access
					end
				end
				laser310_pkg::SETUP:
					state <= laser310_pkg::LATCH;
				laser310_pkg::LATCH:
					state <= laser310_pkg::FINISH;
				laser310_pkg::FINISH:
				begin
					stretch_cnt <= 4'd0;
					state       <= turbo_q ? laser310_pkg::DONE : laser310_pkg::STRETCH;
				end
				laser310_pkg::STRETCH:
				begin
					stretch_cnt <= stretch_cnt + 4'd1;
					if (stretch_cnt == STRETCH_LAST)
						state <= laser310_pkg::DONE;
				end
				default:
					state <= laser310_pkg::IDLE;	// DONE, request is released next
			endcase
		end
	end

	assign ready_o      = (state == laser310_pkg::DONE);
	assign wr_phase_o   = (state == laser310_pkg::LATCH);	// Writes land at end of LATCH
	assign rd_capture_o = (state == laser310_pkg::FINISH);

endmodule

// File: common/laser310_pkg.sv
package laser310_pkg;

	// Bus widths
	localparam int ADDR_W       = 16;
	localparam int DATA_W       = 8;
	localparam int KEY_MATRIX_W = 64;	// 8 rows x 8 columns, columns 0-5 used
	localparam int KEY_EX_W     = 10;

	// Memory map
	localparam logic [ADDR_W-1:0] IO_LATCH_BASE = 16'h6800;
	localparam logic [ADDR_W-1:0] VRAM_BASE     = 16'h7000;
	localparam logic [ADDR_W-1:0] RAM_BASE      = 16'h7800;
	localparam logic [ADDR_W-1:0] RAM_TOP       = 16'hB7FF;

	// I/O ports
	localparam logic [7:0] SHRG_PORT   = 8'h20;
	localparam logic [3:0] JOY_PORT_HI = 4'h2;
	localparam logic [7:0] SHRG_RESET  = 8'h08;	// GM = 010

	typedef enum logic [2:0] {IDLE, SETUP, LATCH, FINISH, STRETCH, DONE} bus_phase_e;

	typedef enum logic [2:0] {NONE, KEYIO, VRAM, RAM, IOPORT} mem_region_e;

	// Key matrix indices, row * 8 + column
	localparam int KEY_T       = 0;
	localparam int KEY_CTRL    = 10;
	localparam int KEY_A       = 12;
	localparam int KEY_SHIFT_L = 18;
	localparam int KEY_DOT     = 33;
	localparam int KEY_COMMA   = 35;
	localparam int KEY_SPACE   = 36;
	localparam int KEY_M       = 37;
	localparam int KEY_MINUS   = 42;

endpackage

// File: keyboard/key_row_scan.sv
module key_row_scan (
	input  logic [laser310_pkg::KEY_MATRIX_W-1:0] key_matrix_i,
	input  logic [laser310_pkg::KEY_EX_W-1:0]     key_ex_i,
	input  logic [7:0]                            addr_lo_i,
	input  logic                                  cass_in_i,
	output logic [laser310_pkg::DATA_W-1:0]       key_byte_o
);

	logic [laser310_pkg::KEY_MATRIX_W-1:0] keys;

	// Extra keys become Ctrl combinations on the real matrix
	always_comb
	begin
		keys = key_matrix_i;
		keys[laser310_pkg::KEY_DOT]     = key_matrix_i[laser310_pkg::KEY_DOT] & key_ex_i[4];
		keys[laser310_pkg::KEY_M]       = key_matrix_i[laser310_pkg::KEY_M] & key_ex_i[5]
			& key_ex_i[8];
		keys[laser310_pkg::KEY_COMMA]   = key_matrix_i[laser310_pkg::KEY_COMMA] & key_ex_i[6];
		keys[laser310_pkg::KEY_SPACE]   = key_matrix_i[laser310_pkg::KEY_SPACE] & key_ex_i[7];
		keys[laser310_pkg::KEY_MINUS]   = key_matrix_i[laser310_pkg::KEY_MINUS] & key_ex_i[3];
		keys[laser310_pkg::KEY_SHIFT_L] = key_matrix_i[laser310_pkg::KEY_SHIFT_L] & key_ex_i[0];
		keys[laser310_pkg::KEY_CTRL]    = key_matrix_i[laser310_pkg::KEY_CTRL] & (&key_ex_i[8:3]);
	end

	// A low address bit selects its row; any pressed key in a selected row pulls its column low
	always_comb
	begin
		key_byte_o = {1'b1, ~cass_in_i, 6'h3F};
		for (int r = 0; r < 8; r++)
		begin
			for (int c = 0; c < 6; c++)
			begin
				if (!addr_lo_i[r] && !keys[r * 8 + c])
					key_byte_o[c] = 1'b0;
			end
		end
	end

endmodule

// File: keyboard/ps2_key_matrix.sv
module ps2_key_matrix (
	input  logic                                  CLK50MHZ,
	input  logic                                  RESET_N,
	input  logic                                  key_strobe_i,
	input  logic [7:0]                            key_code_i,
	input  logic                                  key_pressed_i,
	input  logic                                  key_extended_i,
	output logic [laser310_pkg::KEY_MATRIX_W-1:0] key_matrix_o,
	output logic [laser310_pkg::KEY_EX_W-1:0]     key_ex_o
);

	logic key_n;

	assign key_n = ~key_pressed_i;	// Matrix is active low

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			key_matrix_o <= '1;
			key_ex_o     <= '1;
		end
		else if (key_strobe_i)
		begin
			case (key_code_i)
				8'h16: key_matrix_o[28] <= key_n;	// 1
				8'h1E: key_matrix_o[25] <= key_n;	// 2
				8'h26: key_matrix_o[27] <= key_n;	// 3
				8'h25: key_matrix_o[29] <= key_n;	// 4
				8'h2E: key_matrix_o[24] <= key_n;	// 5
				8'h36: key_matrix_o[40] <= key_n;	// 6
				8'h3D: key_matrix_o[45] <= key_n;	// 7
				8'h3E: key_matrix_o[43] <= key_n;	// 8
				8'h46: key_matrix_o[41] <= key_n;	// 9
				8'h45: key_matrix_o[44] <= key_n;	// 0
				8'h4E: key_matrix_o[laser310_pkg::KEY_MINUS] <= key_n;
				8'h49: key_matrix_o[laser310_pkg::KEY_DOT] <= key_n;
				8'h41: key_matrix_o[laser310_pkg::KEY_COMMA] <= key_n;
				8'h29: key_matrix_o[laser310_pkg::KEY_SPACE] <= key_n;
				8'h3A: key_matrix_o[laser310_pkg::KEY_M] <= key_n;
				8'h2C: key_matrix_o[laser310_pkg::KEY_T] <= key_n;
				8'h1C: key_matrix_o[laser310_pkg::KEY_A] <= key_n;
				8'h15: key_matrix_o[4] <= key_n;	// Q
				8'h1D: key_matrix_o[1] <= key_n;	// W
				8'h24: key_matrix_o[3] <= key_n;	// E
				8'h2D: key_matrix_o[5] <= key_n;	// R
				8'h35: key_matrix_o[48] <= key_n;	// Y
				8'h3C: key_matrix_o[53] <= key_n;	// U
				8'h43: key_matrix_o[51] <= key_n;	// I
				8'h44: key_matrix_o[49] <= key_n;	// O
				8'h4D: key_matrix_o[52] <= key_n;	// P
				8'h1B: key_matrix_o[9] <= key_n;	// S
				8'h23: key_matrix_o[11] <= key_n;	// D
				8'h2B: key_matrix_o[13] <= key_n;	// F
				8'h34: key_matrix_o[8] <= key_n;	// G
				8'h33: key_matrix_o[56] <= key_n;	// H
				8'h3B: key_matrix_o[61] <= key_n;	// J
				8'h42: key_matrix_o[59] <= key_n;	// K
				8'h4B: key_matrix_o[57] <= key_n;	// L
				8'h4C: key_matrix_o[60] <= key_n;	// ;
				8'h52: key_matrix_o[58] <= key_n;	// ' mapped to colon
				8'h1A: key_matrix_o[20] <= key_n;	// Z
				8'h22: key_matrix_o[17] <= key_n;	// X
				8'h21: key_matrix_o[19] <= key_n;	// C
				8'h2A: key_matrix_o[21] <= key_n;	// V
				8'h32: key_matrix_o[16] <= key_n;	// B
				8'h31: key_matrix_o[32] <= key_n;	// N
				8'h5A: key_matrix_o[50] <= key_n;	// Return
				8'h14: key_matrix_o[laser310_pkg::KEY_CTRL] <= key_n;	// Either Ctrl
				8'h12: key_matrix_o[laser310_pkg::KEY_SHIFT_L] <= key_n;
				8'h59: key_ex_o[0] <= key_n;	// R-Shift
				8'h11:
				begin
					// Left and right Alt share a code
					if (key_extended_i)
						key_ex_o[2] <= key_n;
					else
						key_ex_o[1] <= key_n;
				end
				8'h76: key_ex_o[3] <= key_n;	// Esc
				8'h75: key_ex_o[4] <= key_n;	// Up
				8'h6B: key_ex_o[5] <= key_n;	// Left
				8'h74: key_ex_o[6] <= key_n;	// Right
				8'h72: key_ex_o[7] <= key_n;	// Down
				8'h66: key_ex_o[8] <= key_n;	// Backspace
				default: ;
			endcase
		end
	end

endmodule

// File: sim/laser310_assert.sv
module laser310_assert (
	input logic CLK50MHZ,
	input logic RESET_N,
	input logic valid_i,
	input logic ready_i,
	input logic wr_phase_i
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [1:0] wr_count;	// Write phases in the current access
	int         ready_fails = 0;
	int         valid_fails = 0;
	int         write_fails = 0;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
			wr_count <= 2'd0;
		else if (ready_i)
			wr_count <= 2'd0;
		else if (wr_phase_i && wr_count != 2'd3)
			wr_count <= wr_count + 2'd1;
	end

	ready_one_cycle: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		ready_i |=> !ready_i)
	else
	begin
		$error("bus ready held for more than one cycle");
		ready_fails++;
	end

	ready_needs_valid: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		$rose(ready_i) |-> valid_i)
	else
	begin
		$error("bus ready rose with no request pending");
		valid_fails++;
	end

	// Exactly one write phase before each ready
	one_write_phase: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		ready_i |-> wr_count == 2'd1)
	else
	begin
		$error("write phase count per access is not one");
		write_fails++;
	end

endmodule

bind bus_cycle_seq laser310_assert assert_inst (
	.CLK50MHZ   (CLK50MHZ),
	.RESET_N    (RESET_N),
	.valid_i    (valid_i),
	.ready_i    (ready_o),
	.wr_phase_i (wr_phase_o)
);

// File: sim/tb_laser310_tasks.svh
// Taps 16, 14, 13, 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
	return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

task automatic random_bits(input int count, output logic [15:0] value);
	value = 16'h0000;
	for (int i = 0; i < count; i++)
	begin
		lfsr  = lfsr_next(lfsr);
		value = {value[14:0], lfsr[0]};	// One step per bit
	end
endtask

// One bus access, held until ready, returns the byte and the cycles taken
task automatic bus_access(input logic write, input logic io, input logic [15:0] addr,
	input logic [7:0] wdata, output logic [7:0] rdata, output int cycles);
	logic seen;
	seen   = 1'b0;
	rdata  = 8'h00;
	cycles = 0;
	@(posedge CLK50MHZ);
	bus_valid_i <= 1'b1;
	bus_write_i <= write;
	bus_io_i    <= io;
	bus_addr_i  <= addr;
	bus_wdata_i <= wdata;
	while (!seen && cycles < READY_TIMEOUT)
	begin
		@(posedge CLK50MHZ);
		cycles = cycles + 1;
		@(negedge CLK50MHZ);
		if (bus_ready_o)
		begin
			seen  = 1'b1;
			rdata = bus_rdata_o;
		end
	end
	if (!seen)
	begin
		$display("No bus ready for address %04h within %0d cycles", addr, READY_TIMEOUT);
		$display("Test FAILED");
		$finish;
	end
	else
	begin
		@(posedge CLK50MHZ);
		bus_valid_i <= 1'b0;
	end
endtask

task automatic bus_write(input logic io, input logic [15:0] addr, input logic [7:0] data);
	logic [7:0] unused_byte;
	int         unused_cycles;
	bus_access(1'b1, io, addr, data, unused_byte, unused_cycles);
endtask

task automatic bus_read(input logic io, input logic [15:0] addr, output logic [7:0] data);
	int cycles;
	bus_access(1'b0, io, addr, 8'h00, data, cycles);
endtask

// Single-cycle key strobe
task automatic key_event(input logic [7:0] code, input logic extended, input logic pressed);
	@(posedge CLK50MHZ);
	key_strobe_i   <= 1'b1;
	key_code_i     <= code;
	key_extended_i <= extended;
	key_pressed_i  <= pressed;
	@(posedge CLK50MHZ);
	key_strobe_i   <= 1'b0;
endtask

task automatic report_byte(input string name, input logic [7:0] got, input logic [7:0] expected);
	value_errors++;
	$display("FAIL at %0d ns: %s is %02h, expected %02h", $time, name, got, expected);
endtask

task automatic report_count(input string name, input int got, input int expected);
	value_errors++;
	$display("FAIL at %0d ns: %s is %0d cycles, expected %0d", $time, name, got, expected);
endtask

// File: sim/tb_laser310.sv
module tb_laser310;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int READY_TIMEOUT = 40;	// Longest access is 14 cycles
	localparam int RAM_WORDS     = 8;
	localparam logic [7:0] CODE_T  = 8'h2C;
	localparam logic [7:0] CODE_A  = 8'h1C;
	localparam logic [7:0] CODE_UP = 8'h75;	// Sent with the E0 prefix

	logic        CLK50MHZ = 1'b0;
	logic        RESET_N;
	logic        bus_valid_i;
	logic        bus_write_i;
	logic        bus_io_i;
	logic [15:0] bus_addr_i;
	logic [7:0]  bus_wdata_i;
	logic        bus_ready_o;
	logic [7:0]  bus_rdata_o;
	logic        turbo_i;
	logic        shrg_en_i;
	logic        key_strobe_i;
	logic [7:0]  key_code_i;
	logic        key_pressed_i;
	logic        key_extended_i;
	logic        cass_in_i;
	logic [4:0]  joy1_dir_i;	// Bit 0 up, bit 4 fire
	logic        joy1_arm_i;
	logic [4:0]  joy2_dir_i;
	logic        joy2_arm_i;
	logic [1:0]  speaker_o;
	logic        cass_out_o;
	logic        vdg_ag_o;
	logic        vdg_css_o;
	logic [2:0]  vdg_gm_o;

	logic [15:0] lfsr = 16'd9443;
	int          value_errors = 0;
	int          assert_errors;
	logic [7:0]  mem_model [logic [15:0]];	// Last byte written per address
	logic [15:0] written [$];

	laser310_bus_top #(
		.VRAM_DEPTH (2048),
		.RAM_DEPTH  (16384)
	) laser310_bus_top_inst (.*);

	always #10 CLK50MHZ = ~CLK50MHZ;

	`include "tb_laser310_tasks.svh"

	task automatic apply_reset(input logic shrg_switch);
		@(posedge CLK50MHZ);
		RESET_N   <= 1'b0;
		shrg_en_i <= shrg_switch;
		repeat (8) @(posedge CLK50MHZ);
		RESET_N   <= 1'b1;
	endtask

	task automatic test_ram_readback();
		logic [15:0] bits;
		logic [15:0] addr;
		logic [7:0]  got;
		for (int i = 0; i < 2 * RAM_WORDS; i++)
		begin
			random_bits((i < RAM_WORDS) ? 14 : 11, bits);
			addr = (i < RAM_WORDS) ? laser310_pkg::RAM_BASE + bits : laser310_pkg::VRAM_BASE + bits;
			random_bits(8, bits);
			bus_write(1'b0, addr, bits[7:0]);
			mem_model[addr] = bits[7:0];
			written.push_back(addr);
		end
		foreach (written[k])
		begin
			bus_read(1'b0, written[k], got);
			if (got !== mem_model[written[k]])
				report_byte("bus_rdata_o", got, mem_model[written[k]]);
		end
		bus_read(1'b0, 16'h0000, got);	// ROM area, nothing fitted
		if (got !== 8'hFF)
			report_byte("bus_rdata_o", got, 8'hFF);
	endtask

	task automatic test_latency();
		logic [7:0] got;
		int         cycles;
		@(posedge CLK50MHZ);
		turbo_i <= 1'b0;
		bus_access(1'b1, 1'b0, 16'h9000, 8'h5A, got, cycles);
		if (cycles != 14)
			report_count("bus_ready_o latency at normal speed", cycles, 14);
		@(posedge CLK50MHZ);
		turbo_i <= 1'b1;
		bus_access(1'b0, 1'b0, 16'h9000, 8'h00, got, cycles);
		if (cycles != 4)
			report_count("bus_ready_o latency in turbo", cycles, 4);
		if (got !== 8'h5A)
			report_byte("bus_rdata_o", got, 8'h5A);
	endtask

	task automatic test_output_latch();
		bus_write(1'b0, 16'h6800, 8'h3D);
		@(negedge CLK50MHZ);
		if ({speaker_o, cass_out_o, vdg_ag_o, vdg_css_o} !== 5'h1F)
			report_byte("{speaker_o, cass_out_o, vdg_ag_o, vdg_css_o}",
				{3'b000, speaker_o, cass_out_o, vdg_ag_o, vdg_css_o}, 8'h1F);
		bus_write(1'b0, 16'h6800, 8'h00);
		@(negedge CLK50MHZ);
		if ({speaker_o, cass_out_o, vdg_ag_o, vdg_css_o} !== 5'h00)
			report_byte("{speaker_o, cass_out_o, vdg_ag_o, vdg_css_o}",
				{3'b000, speaker_o, cass_out_o, vdg_ag_o, vdg_css_o}, 8'h00);
	endtask

	task automatic test_keyboard();
		logic [7:0] got;
		@(posedge CLK50MHZ);
		cass_in_i <= 1'b1;
		key_event(CODE_T, 1'b0, 1'b1);
		key_event(CODE_A, 1'b0, 1'b1);
		bus_read(1'b0, 16'h68FE, got);	// Row 0
		if (got !== 8'hBE)
			report_byte("bus_rdata_o", got, 8'hBE);
		bus_read(1'b0, 16'h68FD, got);	// Row 1
		if (got !== 8'hAF)
			report_byte("bus_rdata_o", got, 8'hAF);
		key_event(CODE_T, 1'b0, 1'b0);
		key_event(CODE_A, 1'b0, 1'b0);
		key_event(CODE_UP, 1'b1, 1'b1);
		bus_read(1'b0, 16'h68EF, got);	// Dot column
		if (got !== 8'hBD)
			report_byte("bus_rdata_o", got, 8'hBD);
		bus_read(1'b0, 16'h68FD, got);	// Ctrl column
		if (got !== 8'hBB)
			report_byte("bus_rdata_o", got, 8'hBB);
		key_event(CODE_UP, 1'b1, 1'b0);
		bus_read(1'b0, 16'h6800, got);	// All rows at once
		if (got !== 8'hBF)
			report_byte("bus_rdata_o", got, 8'hBF);
		bus_read(1'b0, 16'h68EF, got);
		if (got !== 8'hBF)
			report_byte("bus_rdata_o", got, 8'hBF);
	endtask

	task automatic test_joystick();
		logic [7:0] got;
		@(posedge CLK50MHZ);
		joy1_dir_i <= 5'b10001;	// Up and fire
		bus_read(1'b1, 16'h002E, got);
		if (got !== 8'hEE)
			report_byte("bus_rdata_o", got, 8'hEE);
		@(posedge CLK50MHZ);
		joy2_arm_i <= 1'b1;
		bus_read(1'b1, 16'h0027, got);
		if (got !== 8'hEF)
			report_byte("bus_rdata_o", got, 8'hEF);
		bus_read(1'b1, 16'h002F, got);	// No group selected
		if (got !== 8'hFF)
			report_byte("bus_rdata_o", got, 8'hFF);
	endtask

	task automatic test_shrg();
		for (int pass = 0; pass < 2; pass++)
		begin
			apply_reset(pass == 0);
			@(negedge CLK50MHZ);
			if (vdg_gm_o !== 3'b010)
				report_byte("vdg_gm_o", {5'd0, vdg_gm_o}, 8'h02);
			bus_write(1'b1, 16'h0020, 8'h14);
			@(negedge CLK50MHZ);
			if (vdg_gm_o !== ((pass == 0) ? 3'b101 : 3'b010))
				report_byte("vdg_gm_o", {5'd0, vdg_gm_o}, (pass == 0) ? 8'h05 : 8'h02);
		end
	endtask

	initial
	begin
		RESET_N        = 1'b0;
		bus_valid_i    = 1'b0;
		bus_write_i    = 1'b0;
		bus_io_i       = 1'b0;
		bus_addr_i     = 16'h0000;
		bus_wdata_i    = 8'h00;
		turbo_i        = 1'b1;
		shrg_en_i      = 1'b0;
		key_strobe_i   = 1'b0;
		key_code_i     = 8'h00;
		key_pressed_i  = 1'b0;
		key_extended_i = 1'b0;
		cass_in_i      = 1'b0;
		joy1_dir_i     = 5'd0;
		joy1_arm_i     = 1'b0;
		joy2_dir_i     = 5'd0;
		joy2_arm_i     = 1'b0;
		repeat (8) @(posedge CLK50MHZ);
		RESET_N <= 1'b1;

		test_ram_readback();
		test_latency();
		test_output_latch();
		test_keyboard();
		test_joystick();
		test_shrg();

		assert_errors = laser310_bus_top_inst.seq_inst.assert_inst.ready_fails
			+ laser310_bus_top_inst.seq_inst.assert_inst.valid_fails
			+ laser310_bus_top_inst.seq_inst.assert_inst.write_fails;
		$display("Value errors: %0d, assertion errors: %0d", value_errors, assert_errors);
		if (value_errors == 0 && assert_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: source/io_ports.sv
module io_ports (
	input  logic                            CLK50MHZ,
	input  logic                            RESET_N,
	input  logic                            shrg_en_i,
	input  logic [laser310_pkg::DATA_W-1:0] wdata_i,
	input  logic [7:0]                      addr_lo_i,
	input  logic                            io_latch_we_i,
	input  logic                            shrg_we_i,
	input  logic [4:0]                      joy1_dir_i,
	input  logic                            joy1_arm_i,
	input  logic [4:0]                      joy2_dir_i,
	input  logic                            joy2_arm_i,
	output logic [laser310_pkg::DATA_W-1:0] joy_byte_o,
	output logic [1:0]                      speaker_o,
	output logic                            cass_out_o,
	output logic                            vdg_ag_o,
	output logic                            vdg_css_o,
	output logic [2:0]                      vdg_gm_o
);

	logic [laser310_pkg::DATA_W-1:0] out_latch;
	logic [laser310_pkg::DATA_W-1:0] shrg_latch;
	logic                            shrg_en_q;

	// Switch is taken only while reset is held
	always_ff @(posedge CLK50MHZ)
	begin
		if (!RESET_N)
			shrg_en_q <= shrg_en_i;
	end

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			out_latch  <= 8'h00;
			shrg_latch <= laser310_pkg::SHRG_RESET;
		end
		else
		begin
			if (io_latch_we_i)
				out_latch <= wdata_i;
			if (shrg_we_i && shrg_en_q)
				shrg_latch <= wdata_i;
		end
	end

	assign speaker_o  = {out_latch[0], out_latch[5]};
	assign cass_out_o = out_latch[2];
	assign vdg_ag_o   = out_latch[3];
	assign vdg_css_o  = out_latch[4];
	assign vdg_gm_o   = shrg_latch[4:2];

	// Each low address bit enables one group, groups are wired-AND
	always_comb
	begin
		joy_byte_o = 8'hFF;
		if (addr_lo_i[7:4] == laser310_pkg::JOY_PORT_HI)
		begin
			if (!addr_lo_i[0])
				joy_byte_o = joy_byte_o & {3'b111, ~joy1_dir_i};
			if (!addr_lo_i[1])
				joy_byte_o = joy_byte_o & {3'b111, ~joy1_arm_i, 4'hF};
			if (!addr_lo_i[2])
				joy_byte_o = joy_byte_o & {3'b111, ~joy2_dir_i};
			if (!addr_lo_i[3])
				joy_byte_o = joy_byte_o & {3'b111, ~joy2_arm_i, 4'hF};
		end
	end

endmodule

// File: source/laser310_bus_top.sv
module laser310_bus_top #(
	parameter int VRAM_DEPTH = 2048,
	parameter int RAM_DEPTH  = 16384
) (
	input  logic                             CLK50MHZ,
	input  logic                             RESET_N,
	input  logic                             bus_valid_i,
	input  logic                             bus_write_i,
	input  logic                             bus_io_i,
	input  logic [laser310_pkg::ADDR_W-1:0]  bus_addr_i,
	input  logic [laser310_pkg::DATA_W-1:0]  bus_wdata_i,
	output logic                             bus_ready_o,
	output logic [laser310_pkg::DATA_W-1:0]  bus_rdata_o,
	input  logic                             turbo_i,
	input  logic                             shrg_en_i,
	input  logic                             key_strobe_i,
	input  logic [7:0]                       key_code_i,
	input  logic                             key_pressed_i,
	input  logic                             key_extended_i,
	input  logic                             cass_in_i,
	input  logic [4:0]                       joy1_dir_i,	// up, down, left, right, fire
	input  logic                             joy1_arm_i,
	input  logic [4:0]                       joy2_dir_i,
	input  logic                             joy2_arm_i,
	output logic [1:0]                       speaker_o,
	output logic                             cass_out_o,
	output logic                             vdg_ag_o,
	output logic                             vdg_css_o,
	output logic [2:0]                       vdg_gm_o
);

	logic                                    wr_phase;
	logic                                    rd_capture;
	logic                                    io_latch_we;
	logic                                    shrg_we;
	logic [laser310_pkg::DATA_W-1:0]         key_byte;
	logic [laser310_pkg::DATA_W-1:0]         joy_byte;
	logic [laser310_pkg::KEY_MATRIX_W-1:0]   key_matrix;
	logic [laser310_pkg::KEY_EX_W-1:0]       key_ex;

	bus_cycle_seq seq_inst (
		.CLK50MHZ     (CLK50MHZ),
		.RESET_N      (RESET_N),
		.valid_i      (bus_valid_i),
		.turbo_i      (turbo_i),
		.ready_o      (bus_ready_o),
		.wr_phase_o   (wr_phase),
		.rd_capture_o (rd_capture)
	);

	memory_map #(
		.VRAM_DEPTH (VRAM_DEPTH),
		.RAM_DEPTH  (RAM_DEPTH)
	) map_inst (
		.CLK50MHZ      (CLK50MHZ),
		.RESET_N       (RESET_N),
		.addr_i        (bus_addr_i),
		.wdata_i       (bus_wdata_i),
		.write_i       (bus_write_i),
		.io_i          (bus_io_i),
		.wr_phase_i    (wr_phase),
		.rd_capture_i  (rd_capture),
		.key_byte_i    (key_byte),
		.joy_byte_i    (joy_byte),
		.rdata_o       (bus_rdata_o),
		.io_latch_we_o (io_latch_we),
		.shrg_we_o     (shrg_we)
	);

	io_ports io_inst (
		.CLK50MHZ      (CLK50MHZ),
		.RESET_N       (RESET_N),
		.shrg_en_i     (shrg_en_i),
		.wdata_i       (bus_wdata_i),
		.addr_lo_i     (bus_addr_i[7:0]),
		.io_latch_we_i (io_latch_we),
		.shrg_we_i     (shrg_we),
		.joy1_dir_i    (joy1_dir_i),
		.joy1_arm_i    (joy1_arm_i),
		.joy2_dir_i    (joy2_dir_i),
		.joy2_arm_i    (joy2_arm_i),
		.joy_byte_o    (joy_byte),
		.speaker_o     (speaker_o),
		.cass_out_o    (cass_out_o),
		.vdg_ag_o      (vdg_ag_o),
		.vdg_css_o     (vdg_css_o),
		.vdg_gm_o      (vdg_gm_o)
	);

	ps2_key_matrix kbd_inst (
		.CLK50MHZ       (CLK50MHZ),
		.RESET_N        (RESET_N),
		.key_strobe_i   (key_strobe_i),
		.key_code_i     (key_code_i),
		.key_pressed_i  (key_pressed_i),
		.key_extended_i (key_extended_i),
		.key_matrix_o   (key_matrix),
		.key_ex_o       (key_ex)
	);

	key_row_scan scan_inst (
		.key_matrix_i (key_matrix),
		.key_ex_i     (key_ex),
		.addr_lo_i    (bus_addr_i[7:0]),
		.cass_in_i    (cass_in_i),
		.key_byte_o   (key_byte)
	);

endmodule

// File: source/memory_map.sv
module memory_map #(
	parameter int VRAM_DEPTH = 2048,
	parameter int RAM_DEPTH  = 16384
) (
	input  logic                            CLK50MHZ,
	input  logic                            RESET_N,
	input  logic [laser310_pkg::ADDR_W-1:0] addr_i,
	input  logic [laser310_pkg::DATA_W-1:0] wdata_i,
	input  logic                            write_i,
	input  logic                            io_i,
	input  logic                            wr_phase_i,
	input  logic                            rd_capture_i,
	input  logic [laser310_pkg::DATA_W-1:0] key_byte_i,
	input  logic [laser310_pkg::DATA_W-1:0] joy_byte_i,
	output logic [laser310_pkg::DATA_W-1:0] rdata_o,
	output logic                            io_latch_we_o,
	output logic                            shrg_we_o
);

	localparam int VRAM_AW = $clog2(VRAM_DEPTH);
	localparam int RAM_AW  = $clog2(RAM_DEPTH);

	laser310_pkg::mem_region_e         region;
	logic                              wr_strobe;
	logic                              vram_we;
	logic                              ram_we;
	logic [laser310_pkg::DATA_W-1:0]   vram_q;
	logic [laser310_pkg::DATA_W-1:0]   ram_q;

	always_comb
	begin
		region = laser310_pkg::NONE;
		if (io_i)
		begin
			if (addr_i[7:4] == laser310_pkg::JOY_PORT_HI)
				region = laser310_pkg::IOPORT;
		end
		else if (addr_i[15:11] == laser310_pkg::IO_LATCH_BASE[15:11])
			region = laser310_pkg::KEYIO;	// 6800-6FFF
		else if (addr_i[15:11] == laser310_pkg::VRAM_BASE[15:11])
			region = laser310_pkg::VRAM;
		else if (addr_i >= laser310_pkg::RAM_BASE && addr_i <= laser310_pkg::RAM_TOP)
			region = laser310_pkg::RAM;
	end

	assign wr_strobe     = wr_phase_i & write_i;
	assign vram_we       = wr_strobe & (region == laser310_pkg::VRAM);
	assign ram_we        = wr_strobe & (region == laser310_pkg::RAM);
	assign io_latch_we_o = wr_strobe & (region == laser310_pkg::KEYIO);
	assign shrg_we_o     = wr_strobe & io_i & (addr_i[7:0] == laser310_pkg::SHRG_PORT);

	system_ram #(.DEPTH(VRAM_DEPTH)) vram_inst (
		.CLK50MHZ (CLK50MHZ),
		.addr_i   (addr_i[VRAM_AW-1:0]),
		.wdata_i  (wdata_i),
		.we_i     (vram_we),
		.rdata_o  (vram_q)
	);

	// 7800-7FFF folds onto the top 2 KB, 8000-B7FF onto the bottom
	system_ram #(.DEPTH(RAM_DEPTH)) ram_inst (
		.CLK50MHZ (CLK50MHZ),
		.addr_i   (addr_i[RAM_AW-1:0]),
		.wdata_i  (wdata_i),
		.we_i     (ram_we),
		.rdata_o  (ram_q)
	);

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
			rdata_o <= 8'hFF;
		else if (rd_capture_i)
		begin
			case (region)
				laser310_pkg::KEYIO:  rdata_o <= key_byte_i;
				laser310_pkg::VRAM:   rdata_o <= vram_q;
				laser310_pkg::RAM:    rdata_o <= ram_q;
				laser310_pkg::IOPORT: rdata_o <= joy_byte_i;
				default:              rdata_o <= 8'hFF;	// ROM and open bus
			endcase
		end
	end

endmodule

// File: source/system_ram.sv
module system_ram #(
	parameter int DEPTH = 2048
) (
	input  logic                            CLK50MHZ,
	input  logic [$clog2(DEPTH)-1:0]        addr_i,
	input  logic [laser310_pkg::DATA_W-1:0] wdata_i,
	input  logic                            we_i,
	output logic [laser310_pkg::DATA_W-1:0] rdata_o
);

	logic [laser310_pkg::DATA_W-1:0] mem [DEPTH];

	always_ff @(posedge CLK50MHZ)
	begin
		if (we_i)
			mem[addr_i] <= wdata_i;
		rdata_o <= mem[addr_i];	// Read before write on the same address
	end

endmodule

// File: tb.f
+incdir+sim
common/laser310_pkg.sv
bus_cycle/bus_cycle_seq.sv
source/system_ram.sv
source/memory_map.sv
source/io_ports.sv
keyboard/ps2_key_matrix.sv
keyboard/key_row_scan.sv
source/laser310_bus_top.sv
sim/laser310_assert.sv
sim/tb_laser310.sv
